// ==== verilog.f ====
+incdir+include
src/pixel_pkg.sv
src/csr_pkg.sv
src/colorbar_gen.sv
src/frame_sync.sv
src/bayer_stats.sv
src/csr_bank.sv
src/awb_stats_top.sv
testbench/tb_awb_stats.sv

// ==== Bender.yml ====
package:
  name: awb_stats

export_include_dirs:
  - include

sources:
  - src/pixel_pkg.sv
  - src/csr_pkg.sv
  - src/colorbar_gen.sv
  - src/frame_sync.sv
  - src/bayer_stats.sv
  - src/csr_bank.sv
  - src/awb_stats_top.sv
  - target: test
    files:
      - testbench/tb_awb_stats.sv

// ==== testbench/tb_awb_stats.sv ====
// Self-checking testbench for awb_stats_top, compiled from verilog.f with tb_awb_stats as top
`include "awb_config.svh"

module tb_awb_stats;

  timeunit 1ns;
  timeprecision 1ps;

  import pixel_pkg::*;
  import csr_pkg::*;

  localparam int NUM_FRAMES = 8;  // Random sensor frames
  localparam int NUM_OFF    = 2;  // Trailing frames with stats off
  localparam int CSR_CYCLES = 64; // Irq wait and readback per frame
  localparam int PATT_LEN   = (`AWB_NUM_COLS + `AWB_H_BLANK) * `AWB_NUM_ROWS + `AWB_V_BLANK;
  localparam int PER_CHAN   = `AWB_NUM_COLS * `AWB_NUM_ROWS / 4; // Window pixels per channel

  logic      clk_i = 1'b0;
  logic      rst_i;
  pix_beat_s sensor_i;
  csr_req_s  csr_req_i;
  pix_beat_s pix_o;
  csr_word_t csr_rdata_o;
  logic      csr_rvalid_o;
  logic      frame_irq_o;

  int        fw  [NUM_FRAMES]; // Columns per frame
  int        fh  [NUM_FRAMES]; // Rows per frame
  int        fhb [NUM_FRAMES]; // Line blanking
  int        fvb [NUM_FRAMES]; // Extra frame blanking
  pixel_t    img [24][12];     // Last frame, [col][row]
  int        limit;
  int        cycles      = 0;
  int        frames_exp  = 0;     // Frames ended with stats on
  logic      chk_pix     = 1'b0;  // Sensor passthrough check
  logic      chk_bar     = 1'b0;  // Colorbar rule check
  int        bar_col     = 0;     // Pixel position in the pix_o line
  pix_beat_s prev_sensor = '0;

  always #50 clk_i = ~clk_i; // 100 ns pixel clock

  awb_stats_top i_awb_stats_top (
    .clk_i       (clk_i       ),
    .rst_i       (rst_i       ),
    .sensor_i    (sensor_i    ),
    .csr_req_i   (csr_req_i   ),
    .pix_o       (pix_o       ),
    .csr_rdata_o (csr_rdata_o ),
    .csr_rvalid_o(csr_rvalid_o),
    .frame_irq_o (frame_irq_o )
  );

  // ******************************
  // Checks
  // ******************************
  task automatic abort_run(string why);
    $display("%s", why);
    $display("Simulation FAILED");
    $fatal(1, "Stopped at the first error");
  endtask

  task automatic check_beat(string name, pix_beat_s exp, pix_beat_s act);
    if (exp !== act) abort_run($sformatf("[ERROR] %s expected %h actual %h", name, exp, act));
  endtask

  task automatic check_avg(string name, chan_avg_s exp, chan_avg_s act);
    if (exp !== act) abort_run($sformatf("[ERROR] %s expected %h actual %h", name, exp, act));
  endtask

  task automatic check_word(string name, csr_word_t exp, csr_word_t act);
    if (exp !== act) abort_run($sformatf("[ERROR] %s expected %h actual %h", name, exp, act));
  endtask

  // Bar index in the top three bits, eight bars over the width
  function automatic pixel_t bar_pixel(int col);
    return pixel_t'((col / (`AWB_NUM_COLS / 8)) << (`AWB_PIXEL_BITS - 3));
  endfunction

  // Window sums per {row[0], col[0]}, divided by pixels per channel
  function automatic chan_avg_s model_avg(int w, int h);
    int sum [4] = '{default: 0};
    int ch;
    for (int r = 0; r < h && r < `AWB_NUM_ROWS; r++) begin
      for (int c = 0; c < w && c < `AWB_NUM_COLS; c++) begin
        ch      = 2 * (r % 2) + (c % 2);
        sum[ch] += img[c][r];
      end
    end
    model_avg.ch0 = pixel_t'(sum[0] / PER_CHAN);
    model_avg.ch1 = pixel_t'(sum[1] / PER_CHAN);
    model_avg.ch2 = pixel_t'(sum[2] / PER_CHAN);
    model_avg.ch3 = pixel_t'(sum[3] / PER_CHAN);
  endfunction

  // ******************************
  // Drivers
  // ******************************
  task automatic drive_beat(logic f, logic l, pixel_t d);
    @(posedge clk_i);
    sensor_i <= pix_beat_s'{fv: f, lv: l, data: d};
  endtask

  task automatic csr_write(csr_addr_t addr, csr_word_t data);
    @(posedge clk_i);
    csr_req_i <= csr_req_s'{we: 1'b1, re: 1'b0, addr: addr, wdata: data};
    @(posedge clk_i);
    csr_req_i.we <= 1'b0;
  endtask

  // Data must come exactly one cycle after re
  task automatic csr_read(csr_addr_t addr, output csr_word_t data);
    @(posedge clk_i);
    csr_req_i.re   <= 1'b1;
    csr_req_i.addr <= addr;
    @(negedge clk_i);
    if (csr_rvalid_o !== 1'b0) abort_run("csr_rvalid_o high in the cycle of the read strobe");
    @(posedge clk_i);
    csr_req_i.re <= 1'b0;
    @(negedge clk_i);
    if (csr_rvalid_o !== 1'b1) abort_run("csr_rvalid_o missing one cycle after the read strobe");
    data = csr_rdata_o;
  endtask

  task automatic check_reg(string name, csr_addr_t addr, csr_word_t exp);
    csr_word_t rd;
    csr_read(addr, rd);
    check_word(name, exp, rd);
  endtask

  // Front porch, lines with h blank, then the first idle beat
  task automatic drive_sensor_frame(int n);
    drive_beat(1'b1, 1'b0, '0);
    for (int r = 0; r < fh[n]; r++) begin
      for (int c = 0; c < fw[n]; c++) begin
        img[c][r] = pixel_t'($urandom());
        drive_beat(1'b1, 1'b1, img[c][r]);
      end
      if (r < fh[n] - 1) begin
        repeat (fhb[n]) drive_beat(1'b1, 1'b0, pixel_t'($urandom()));
      end
    end
    drive_beat(1'b0, 1'b0, '0); // fv drops right after the last pixel
  endtask

  // Irq expected lat cycles after the edge that drops fv, negative for none
  task automatic expect_irq_at(int lat);
    for (int n = 0; n < 6; n++) begin
      @(negedge clk_i);
      if (frame_irq_o !== (n == lat)) begin
        abort_run($sformatf("frame_irq_o was %b %0d cycles after fv fell", frame_irq_o, n));
      end
    end
  endtask

  task automatic wait_frame_irq(int max_cycles);
    int n = 0;
    do begin
      @(negedge clk_i);
      n++;
      if (n > max_cycles) abort_run("No frame_irq_o at the end of a colorbar frame");
    end while (frame_irq_o !== 1'b1);
  endtask

  task automatic check_stats(string name, int w, int h);
    csr_word_t rd;
    csr_word_t hi = '0; // Bits above the pixel width
    chan_avg_s act;
    chan_avg_s exp;
    exp = model_avg(w, h);
    csr_read(`AWB_ADDR_AVG0, rd);
    act.ch0 = pixel_t'(rd);
    hi      |= rd >> `AWB_PIXEL_BITS;
    csr_read(`AWB_ADDR_AVG1, rd);
    act.ch1 = pixel_t'(rd);
    hi      |= rd >> `AWB_PIXEL_BITS;
    csr_read(`AWB_ADDR_AVG2, rd);
    act.ch2 = pixel_t'(rd);
    hi      |= rd >> `AWB_PIXEL_BITS;
    csr_read(`AWB_ADDR_AVG3, rd);
    act.ch3 = pixel_t'(rd);
    hi      |= rd >> `AWB_PIXEL_BITS;
    check_avg(name, exp, act);
    check_word({name, " avg zero fill"}, '0, hi);
    csr_read(`AWB_ADDR_SIZE, rd);
    check_word({name, " size"}, {16'(h), 16'(w)}, rd); // Rows high, columns low
    csr_read(`AWB_ADDR_FRAMES, rd);
    check_word({name, " frames"}, frames_exp, rd);
  endtask

  // ******************************
  // Monitors
  // ******************************
  always @(negedge clk_i) begin
    if (chk_pix) check_beat("sensor passthrough", prev_sensor, pix_o);
    if (!pix_o.lv) begin
      bar_col = 0;
    end else begin
      if (chk_bar) begin
        check_beat("colorbar pixel", pix_beat_s'{fv: 1'b1, lv: 1'b1, data: bar_pixel(bar_col)},
                   pix_o);
      end
      bar_col++;
    end
    prev_sensor = sensor_i; // pix_o shows it one cycle later
  end

  always @(posedge clk_i) begin
    cycles++;
    if (cycles > limit) abort_run($sformatf("Timeout after %0d cycles", cycles));
  end

  // ******************************
  // Test sequence
  // ******************************
  initial begin
    csr_word_t wd;
    void'($urandom(32'h6c79_689f));
    rst_i     = 1'b1;
    sensor_i  = '0;
    csr_req_i = '0;
    limit     = 200 + 3 * PATT_LEN; // Colorbar frames and setup
    for (int n = 0; n < NUM_FRAMES; n++) begin
      fw[n]  = 4 + $urandom_range(20);
      fh[n]  = 2 + $urandom_range(10);
      fhb[n] = 2 + $urandom_range(4);
      fvb[n] = 2 + $urandom_range(6);
      limit  += 2 + fw[n] * fh[n] + (fh[n] - 1) * fhb[n] + fvb[n] + CSR_CYCLES;
    end
    repeat (4) @(posedge clk_i);
    rst_i <= 1'b0;

    check_reg("ctrl after reset", `AWB_ADDR_CTRL, '0);
    check_reg("frames after reset", `AWB_ADDR_FRAMES, '0);
    check_reg("size after reset", `AWB_ADDR_SIZE, '0);
    chk_pix = 1'b1;

    // Stats on with random reserved bits, sensor kept
    wd = ($urandom() & ~32'h2) | 32'h1;
    csr_write(`AWB_ADDR_CTRL, wd);
    check_reg("ctrl readback", `AWB_ADDR_CTRL, 32'h1);
    csr_write(`AWB_ADDR_FRAMES, $urandom());
    check_reg("frames read only", `AWB_ADDR_FRAMES, '0);
    csr_write(`AWB_ADDR_SIZE, $urandom());
    check_reg("size read only", `AWB_ADDR_SIZE, '0);
    csr_write(3'd7, $urandom());
    check_reg("unmapped address", 3'd7, '0);
    check_reg("ctrl after other writes", `AWB_ADDR_CTRL, 32'h1);

    for (int n = 0; n < NUM_FRAMES; n++) begin
      if (n == NUM_FRAMES - NUM_OFF) begin
        csr_write(`AWB_ADDR_CTRL, 32'h0);
        check_reg("ctrl stats off", `AWB_ADDR_CTRL, 32'h0);
      end
      drive_sensor_frame(n);
      if (n < NUM_FRAMES - NUM_OFF) begin
        expect_irq_at(2);
        frames_exp++;
        check_stats($sformatf("sensor frame %0d", n), fw[n], fh[n]);
      end else begin
        expect_irq_at(-1); // No pulse and no count
        check_reg($sformatf("frames held %0d", n), `AWB_ADDR_FRAMES, frames_exp);
      end
      repeat (fvb[n]) drive_beat(1'b0, 1'b0, pixel_t'($urandom()));
    end

    // Colorbar takes over while the sensor idles
    chk_pix = 1'b0;
    csr_write(`AWB_ADDR_CTRL, 32'h3);
    wait_frame_irq(2 * PATT_LEN); // First frame may be cut by the switch
    frames_exp++;
    chk_bar = 1'b1;
    for (int r = 0; r < `AWB_NUM_ROWS; r++) begin
      for (int c = 0; c < `AWB_NUM_COLS; c++) img[c][r] = bar_pixel(c);
    end
    for (int k = 0; k < 2; k++) begin
      wait_frame_irq(PATT_LEN + 8);
      frames_exp++;
      check_stats($sformatf("colorbar frame %0d", k), `AWB_NUM_COLS, `AWB_NUM_ROWS);
    end

    $display("Simulation PASSED");
    $finish;
  end

endmodule

// ==== src/awb_stats_top.sv ====
// Top level of the AWB statistics path in the pixel clock domain, instances and wiring only
module awb_stats_top (
  input  logic                 clk_i       , // pixel_clk
  input  logic                 rst_i       , // Synchronous to clk_i
  input  pixel_pkg::pix_beat_s sensor_i    , // Raw Bayer input
  input  csr_pkg::csr_req_s    csr_req_i   ,
  output pixel_pkg::pix_beat_s pix_o       , // Passthrough to the transmitter
  output csr_pkg::csr_word_t   csr_rdata_o ,
  output logic                 csr_rvalid_o,
  output logic                 frame_irq_o   // One cycle per finished frame
);

  import pixel_pkg::*;
  import csr_pkg::*;

  pix_beat_s pattern_beat; // Colorbar to source select
  pix_beat_s pix_beat;     // Selected and registered stream
  ctrl_s     ctrl;
  stats_s    stats;
  logic      frame_done;

  // ******************************
  // Pixel path
  // ******************************
  colorbar_gen i_colorbar_gen (
    .clk_i    (clk_i       ),
    .rst_i    (rst_i       ),
    .pattern_o(pattern_beat)
  );

  frame_sync i_frame_sync (
    .clk_i       (clk_i          ),
    .rst_i       (rst_i          ),
    .sensor_i    (sensor_i       ),
    .pattern_i   (pattern_beat   ),
    .pattern_en_i(ctrl.pattern_en),
    .pix_o       (pix_beat       )
  );

  bayer_stats i_bayer_stats (
    .clk_i       (clk_i        ),
    .rst_i       (rst_i        ),
    .pix_i       (pix_beat     ),
    .stats_en_i  (ctrl.stats_en),
    .stats_o     (stats        ),
    .frame_done_o(frame_done   )
  );

  // Registers
  csr_bank i_csr_bank (
    .clk_i       (clk_i       ),
    .rst_i       (rst_i       ),
    .req_i       (csr_req_i   ),
    .stats_i     (stats       ),
    .frame_done_i(frame_done  ),
    .ctrl_o      (ctrl        ),
    .rdata_o     (csr_rdata_o ),
    .rvalid_o    (csr_rvalid_o)
  );

  assign pix_o       = pix_beat;
  assign frame_irq_o = frame_done; // Stats latched on the same edge

endmodule

// ==== src/csr_bank.sv ====
// Register bank on the pixel clock: control bits, frame counter and statistics readback
`include "awb_config.svh"

module csr_bank (
  input  logic               clk_i       , // pixel_clk
  input  logic               rst_i       ,
  input  csr_pkg::csr_req_s  req_i       ,
  input  pixel_pkg::stats_s  stats_i     , // Latched by bayer_stats
  input  logic               frame_done_i,
  output csr_pkg::ctrl_s     ctrl_o      ,
  output csr_pkg::csr_word_t rdata_o     , // Valid with rvalid_o
  output logic               rvalid_o
);

  import csr_pkg::*;

  ctrl_word_u ctrl_q;   // CTRL as stored
  ctrl_word_u ctrl_wr;  // Write data with reserved bits dropped
  csr_word_t  frames_q; // Frames ended with stats on
  csr_word_t  rd_mux;

  // ******************************
  // Writes
  // ******************************
  always_comb begin
    ctrl_wr.raw         = req_i.wdata;
    ctrl_wr.fields.rsvd = '0; // Keeps zero readback
  end

  // Only CTRL is writable
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      ctrl_q.raw <= '0; // Stats off, sensor selected
    end else if (req_i.we && (req_i.addr == `AWB_ADDR_CTRL)) begin
      ctrl_q <= ctrl_wr;
    end
  end

  assign ctrl_o = ctrl_q.fields;

  // Frame counter
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      frames_q <= '0;
    end else if (frame_done_i) begin
      frames_q <= frames_q + 1'b1; // Same edge as the strobe
    end
  end

  // ******************************
  // Reads
  // ******************************
  always_comb begin
    case (req_i.addr)
      `AWB_ADDR_CTRL   : rd_mux = ctrl_q.raw;
      `AWB_ADDR_SIZE   : rd_mux = {16'(stats_i.rows), 16'(stats_i.cols)};
      `AWB_ADDR_FRAMES : rd_mux = frames_q;
      `AWB_ADDR_AVG0   : rd_mux = csr_word_t'(stats_i.avg.ch0);
      `AWB_ADDR_AVG1   : rd_mux = csr_word_t'(stats_i.avg.ch1);
      `AWB_ADDR_AVG2   : rd_mux = csr_word_t'(stats_i.avg.ch2);
      `AWB_ADDR_AVG3   : rd_mux = csr_word_t'(stats_i.avg.ch3);
      default          : rd_mux = '0; // Unmapped
    endcase
  end

  // Read data one cycle after re
  always_ff @(posedge clk_i) begin
    if (req_i.re) begin
      rdata_o <= rd_mux;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) rvalid_o <= 1'b0;
    else       rvalid_o <= req_i.re;
  end

  // Master side rule of the strobe bus
  a_no_rw_overlap : assert property (
    @(posedge clk_i) disable iff (rst_i)
    !(req_i.we && req_i.re)
  ) else $error("we and re high together");

endmodule

// ==== src/bayer_stats.sv ====
// Per-channel Bayer accumulation over a fixed window, results latched on every frame end
`include "awb_config.svh"

module bayer_stats (
  input  logic                 clk_i       , // pixel_clk
  input  logic                 rst_i       ,
  input  pixel_pkg::pix_beat_s pix_i       , // Registered stream from frame_sync
  input  logic                 stats_en_i  ,
  output pixel_pkg::stats_s    stats_o     , // Held until the next frame end
  output logic                 frame_done_o  // One cycle strobe
);

  import pixel_pkg::*;

  // Window pixels per channel is a quarter of the window
  localparam int SHIFT = $clog2(`AWB_NUM_COLS * `AWB_NUM_ROWS / 4);
  localparam int SUM_W = `AWB_PIXEL_BITS + SHIFT; // No overflow over the window

  logic             fv_q;      // Previous fv
  logic             lv_q;      // Previous lv
  frame_cnt_t       col_q;     // Column of the current pixel
  frame_cnt_t       row_q;     // Completed lines in this frame
  frame_cnt_t       max_col_q; // Widest completed line
  logic             fv_fall;
  logic             lv_fall;
  logic             in_win;
  logic [      1:0] chan;
  frame_cnt_t       cols_done;
  frame_cnt_t       rows_done;
  logic [SUM_W-1:0] sum_q [4];
  chan_avg_s        avg;

  // ******************************
  // Position tracking
  // ******************************
  always_comb begin
    fv_fall   = fv_q & ~pix_i.fv;
    lv_fall   = lv_q & ~pix_i.lv;
    chan      = {row_q[0], col_q[0]};
    in_win    = pix_i.lv && stats_en_i
                && (col_q < frame_cnt_t'(`AWB_NUM_COLS))
                && (row_q < frame_cnt_t'(`AWB_NUM_ROWS));
    // Counts including a line that ends right now
    cols_done = (lv_fall && (col_q > max_col_q)) ? col_q : max_col_q;
    rows_done = row_q + frame_cnt_t'(lv_fall);
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      fv_q <= 1'b0;
      lv_q <= 1'b0;
    end else begin
      fv_q <= pix_i.fv;
      lv_q <= pix_i.lv;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i || !pix_i.lv) col_q <= '0; // Restart every line
    else                    col_q <= col_q + 1'b1;
  end

  always_ff @(posedge clk_i) begin
    if (rst_i || !pix_i.fv) begin
      row_q     <= '0;
      max_col_q <= '0;
    end else if (lv_fall) begin
      row_q     <= rows_done;
      max_col_q <= cols_done;
    end
  end

  // ******************************
  // Accumulators
  // ******************************
  // Cleared in blanking, which also covers the fv fall cycle
  always_ff @(posedge clk_i) begin
    for (int i = 0; i < 4; i++) begin
      if (rst_i || !pix_i.fv) begin
        sum_q[i] <= '0;
      end else if (in_win && (chan == 2'(i))) begin
        sum_q[i] <= sum_q[i] + SUM_W'(pix_i.data);
      end
    end
  end

  // Divide by pixels per channel
  always_comb begin
    avg.ch0 = sum_q[0][SUM_W-1:SHIFT];
    avg.ch1 = sum_q[1][SUM_W-1:SHIFT];
    avg.ch2 = sum_q[2][SUM_W-1:SHIFT];
    avg.ch3 = sum_q[3][SUM_W-1:SHIFT];
  end

  // Frame end latch
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      stats_o      <= '0;
      frame_done_o <= 1'b0;
    end else begin
      frame_done_o <= fv_fall & stats_en_i;
      if (fv_fall && stats_en_i) begin
        stats_o.avg  <= avg;
        stats_o.cols <= cols_done;
        stats_o.rows <= rows_done;
      end
    end
  end

  // A frame needs at least one fv high cycle between two ends
  a_done_single : assert property (
    @(posedge clk_i) disable iff (rst_i)
    frame_done_o |=> !frame_done_o
  ) else $error("frame_done_o high for two cycles");

endmodule

// ==== src/frame_sync.sv ====
// Input stage: picks sensor or colorbar at frame boundaries and registers the chosen stream
module frame_sync (
  input  logic                 clk_i       , // pixel_clk
  input  logic                 rst_i       ,
  input  pixel_pkg::pix_beat_s sensor_i    , // Raw Bayer from the sensor
  input  pixel_pkg::pix_beat_s pattern_i   , // Colorbar source
  input  logic                 pattern_en_i, // Requested source, any time
  output pixel_pkg::pix_beat_s pix_o         // Passthrough to TX and stats
);

  import pixel_pkg::*;

  logic      use_patt_q; // Source currently in use
  pix_beat_s sel_beat;

  // Current source mux
  always_comb begin
    sel_beat = use_patt_q ? pattern_i : sensor_i;
  end

  // ******************************
  // Source switch
  // ******************************
  // Only follow the request while the live source is between frames,
  // so an ongoing frame always finishes on the source it started on
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      use_patt_q <= 1'b0; // Sensor after reset
    end else if (!sel_beat.fv) begin
      use_patt_q <= pattern_en_i;
    end
  end

  // One cycle pipeline stage
  always_ff @(posedge clk_i) begin
    pix_o.data <= sel_beat.data;
    if (rst_i) begin
      pix_o.fv <= 1'b0;
      pix_o.lv <= 1'b0;
    end else begin
      pix_o.fv <= sel_beat.fv;
      pix_o.lv <= sel_beat.lv;
    end
  end

  // Either source must keep lines inside frames, including across a switch
  a_lv_inside_fv : assert property (
    @(posedge clk_i) disable iff (rst_i)
    pix_o.lv |-> pix_o.fv
  ) else $error("lv high outside fv on pix_o");

endmodule

// ==== src/colorbar_gen.sv ====
// Eight-bar test pattern source with line and frame blanking, feeds the source select
`include "awb_config.svh"

module colorbar_gen (
  input  logic                 clk_i    , // pixel_clk
  input  logic                 rst_i    ,
  output pixel_pkg::pix_beat_s pattern_o  // Registered beat
);

  import pixel_pkg::*;

  localparam int LINE_LEN = `AWB_NUM_COLS + `AWB_H_BLANK; // Active plus h blank
  localparam int BAR_W    = `AWB_NUM_COLS / 8;            // Pixels per bar
  localparam int COL_W    = $clog2(LINE_LEN);
  localparam int ROW_W    = $clog2(`AWB_NUM_ROWS);
  localparam int VB_W     = $clog2(`AWB_V_BLANK);

  logic [COL_W-1:0] col_q;    // Position in line incl. blanking
  logic [ROW_W-1:0] row_q;
  logic [ VB_W-1:0] vb_cnt_q; // Cycles spent in v blank
  logic             vblank_q;
  logic             active;   // Pixel on this cycle
  logic             last_pix; // Final pixel of the frame
  logic [      2:0] bar_idx;
  pixel_t           bar_pix;

  // ******************************
  // Decode
  // ******************************
  always_comb begin
    active   = ~vblank_q && (col_q < COL_W'(`AWB_NUM_COLS));
    last_pix = ~vblank_q && (col_q == COL_W'(`AWB_NUM_COLS - 1))
               && (row_q == ROW_W'(`AWB_NUM_ROWS - 1));
    bar_idx  = 3'(col_q / BAR_W);
    // Bar index lands in the top three bits
    bar_pix  = active ? {bar_idx, {(`AWB_PIXEL_BITS - 3){1'b0}}} : '0;
  end

  // ******************************
  // Raster counters
  // ******************************
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      col_q    <= '0;
      row_q    <= '0;
      vb_cnt_q <= '0;
      vblank_q <= 1'b1; // Come out of reset between frames
    end else if (vblank_q) begin
      if (vb_cnt_q == VB_W'(`AWB_V_BLANK - 1)) begin
        vb_cnt_q <= '0;
        vblank_q <= 1'b0; // Next cycle is pixel 0 of row 0
      end else begin
        vb_cnt_q <= vb_cnt_q + 1'b1;
      end
    end else if (last_pix) begin
      col_q    <= '0; // No h blank after the last line
      row_q    <= '0;
      vblank_q <= 1'b1;
    end else if (col_q == COL_W'(LINE_LEN - 1)) begin
      col_q <= '0;
      row_q <= row_q + 1'b1;
    end else begin
      col_q <= col_q + 1'b1;
    end
  end

  // Output stage, fv spans first to last pixel
  always_ff @(posedge clk_i) begin
    pattern_o.data <= bar_pix;
    if (rst_i) begin
      pattern_o.fv <= 1'b0;
      pattern_o.lv <= 1'b0;
    end else begin
      pattern_o.fv <= ~vblank_q;
      pattern_o.lv <= active;
    end
  end

endmodule

// ==== src/csr_pkg.sv ====
// Register bus and control word types shared by the register bank and the top level
package csr_pkg;

  // ******************************
  // Bus
  // ******************************

  typedef logic [2:0]  csr_addr_t; // Seven registers in use
  typedef logic [31:0] csr_word_t;

  // One register access, 37 bits
  // we and re are single cycle strobes, never both high
  typedef struct packed {
    logic      we;    // Write in this cycle
    logic      re;    // Read data one cycle later
    csr_addr_t addr;
    csr_word_t wdata;
  } csr_req_s;

  // ******************************
  // Control register
  // ******************************

  // Field view of CTRL, 32 bits
  typedef struct packed {
    logic [29:0] rsvd;       // Read as zero
    logic        pattern_en; // Colorbar replaces sensor
    logic        stats_en;   // Accumulate and raise frame_done
  } ctrl_s;

  // Same word seen raw by the bus and as fields by the datapath
  typedef union packed {
    ctrl_s     fields;
    csr_word_t raw;
  } ctrl_word_u;

endpackage

// ==== src/pixel_pkg.sv ====
// Pixel stream and per-frame statistics types, imported by every block on the pixel path
`include "awb_config.svh"

package pixel_pkg;

  // ******************************
  // Stream
  // ******************************

  // One raw Bayer sample
  typedef logic [`AWB_PIXEL_BITS-1:0] pixel_t;

  // Measured column or row count
  typedef logic [`AWB_CNT_BITS-1:0] frame_cnt_t;

  // One beat of the parallel sensor bus, 12 bits
  typedef struct packed {
    logic   fv;   // Frame valid level
    logic   lv;   // Line valid level
    pixel_t data; // Only meaningful with lv high
  } pix_beat_s;

  // ******************************
  // Statistics
  // ******************************

  // Window average per Bayer channel, 40 bits
  // Channel index is {row[0], col[0]}
  typedef struct packed {
    pixel_t ch0; // Even row, even column
    pixel_t ch1; // Even row, odd column
    pixel_t ch2; // Odd row, even column
    pixel_t ch3; // Odd row, odd column
  } chan_avg_s;

  // Results of one frame, 64 bits
  typedef struct packed {
    chan_avg_s  avg;
    frame_cnt_t cols; // Widest line seen
    frame_cnt_t rows; // Lines in the frame
  } stats_s;

endpackage

// ==== include/awb_config.svh ====
// Window, pixel and register map constants for the AWB statistics path, included where needed
`ifndef AWB_CONFIG_SVH
`define AWB_CONFIG_SVH

// ******************************
// Statistics window
// ******************************
`define AWB_NUM_COLS   16 // Power of two so averages are shifts
`define AWB_NUM_ROWS   8  // Power of two as well
`define AWB_PIXEL_BITS 10 // RAW10 Bayer samples
`define AWB_CNT_BITS   12 // Measured column and row counters

// Colorbar blanking in pixel clocks
`define AWB_H_BLANK 4  // Between pattern lines
`define AWB_V_BLANK 20 // After each pattern frame

// ******************************
// Register map
// ******************************
`define AWB_ADDR_CTRL   3'd0 // stats_en, pattern_en
`define AWB_ADDR_SIZE   3'd1 // Rows high half, columns low half
`define AWB_ADDR_FRAMES 3'd2 // Read only
`define AWB_ADDR_AVG0   3'd3
`define AWB_ADDR_AVG1   3'd4
`define AWB_ADDR_AVG2   3'd5
`define AWB_ADDR_AVG3   3'd6

`endif
